//--- switch_buffer.f
rtl/switch_pkg.sv
rtl/page_word_counter.sv
rtl/free_page_list.sv
rtl/page_buffer.sv
rtl/queue_table.sv
rtl/write_ctrl.sv
rtl/read_sched.sv
rtl/switch_buffer_top.sv
sim/tb_switch_buffer.sv

//--- Bender.yml
package:
  name: switch_buffer

sources:
  - rtl/switch_pkg.sv
  - rtl/page_word_counter.sv
  - rtl/free_page_list.sv
  - rtl/page_buffer.sv
  - rtl/queue_table.sv
  - rtl/write_ctrl.sv
  - rtl/read_sched.sv
  - rtl/switch_buffer_top.sv
  - target: simulation
    files:
      - sim/tb_switch_buffer.sv

//--- sim/tb_switch_buffer.sv
`timescale 1ns/1ps

module tb_switch_buffer
    import switch_pkg::*;
();

    logic                 clk;
    logic                 rst_n;
    logic                 in_vld;
    logic                 in_sop;
    logic                 in_eop;
    logic [DATA_W-1:0]    in_data;
    logic                 in_full;
    logic [NUM_PORTS-1:0] rd_ready;
    logic                 rd_vld;
    logic                 rd_sop;
    logic                 rd_eop;
    logic [PORT_W-1:0]    rd_port;
    logic [DATA_W-1:0]    rd_data;

    // packet store plus one FIFO of packet ids per queue
    logic [DATA_W-1:0] pkt_words [256][MAX_PKT_WORDS];
    int                pkt_len   [256];
    int                q_ids     [NUM_QUEUES][256];
    int                q_head    [NUM_QUEUES];
    int                q_tail    [NUM_QUEUES];
    int                pkts_sent;
    int                pkts_done;

    // output monitor state
    logic              in_pkt;
    int                cur_id;
    int                cur_word;
    int                mon_q;
    logic [PORT_W-1:0] cur_port;
    int                ready_age [NUM_PORTS];
    logic              prio_check;

    switch_buffer_top UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_vld   (in_vld),
        .in_sop   (in_sop),
        .in_eop   (in_eop),
        .in_data  (in_data),
        .in_full  (in_full),
        .rd_ready (rd_ready),
        .rd_vld   (rd_vld),
        .rd_sop   (rd_sop),
        .rd_eop   (rd_eop),
        .rd_port  (rd_port),
        .rd_data  (rd_data)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s is %0h, expected %0h",
                               $time, name, got, exp));
        end
    endtask

    task automatic drive_idle();
        @(posedge clk);
        in_vld <= 1'b0;
        in_sop <= 1'b0;
        in_eop <= 1'b0;
    endtask

    task automatic drive_word(input logic sop, input logic eop, input logic [DATA_W-1:0] data);
        @(posedge clk);
        in_vld  <= 1'b1;
        in_sop  <= sop;
        in_eop  <= eop;
        in_data <= data;
    endtask

    task automatic wait_not_full();
        int n;
        n = 0;
        @(posedge clk);
        while (in_full) begin
            n++;
            if (n > 5000) fail_run("timeout: in_full stayed high before a new packet");
            @(posedge clk);
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (pkts_done != pkts_sent) begin
            n++;
            if (n > 20000) fail_run("timeout: packets still buffered after the drain wait");
            @(posedge clk);
        end
    endtask

    // header word first, random payload, random idle gaps
    task automatic send_packet(input int len, input logic [DATA_W-1:0] hdr);
        int id;
        int q;
        id = pkts_sent;
        q = hdr[HDR_PORT_LSB +: PORT_W] * NUM_PRIOS + hdr[HDR_PRIO_BIT];
        pkt_len[id] = len;
        pkt_words[id][0] = hdr;
        for (int i = 1; i < len; i++) begin
            pkt_words[id][i] = DATA_W'($urandom);
        end
        q_ids[q][q_tail[q]] = id;
        q_tail[q]++;
        pkts_sent++;
        wait_not_full();
        for (int i = 0; i < len; i++) begin
            if (i > 0 && $urandom_range(0, 3) == 0) begin
                repeat ($urandom_range(1, 2)) drive_idle();
            end
            drive_word(i == 0, i == len - 1, pkt_words[id][i]);
        end
        drive_idle();
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                ready_age[p] = rd_ready[p] ? 0 : ready_age[p] + 1;
            end
            if (in_pkt) begin
                check_value("rd_vld", rd_vld, 1);
                check_value("rd_sop", rd_sop, 0);
                check_value("rd_port", rd_port, cur_port);
            end else if (rd_vld) begin
                check_value("rd_sop", rd_sop, 1);
                check_value("rd_port", rd_port, rd_data[HDR_PORT_LSB +: PORT_W]);
                mon_q = rd_port * NUM_PRIOS + rd_data[HDR_PRIO_BIT];
                if (q_head[mon_q] == q_tail[mon_q]) begin
                    fail_run("output packet has no matching packet in the model queue");
                end
                // pick happens at most three cycles before sop
                if (ready_age[rd_port] > 3) begin
                    fail_run("packet came out on a port whose rd_ready was low");
                end
                if (prio_check && !rd_data[HDR_PRIO_BIT]) begin
                    check_value("pending prio 1 packets",
                                q_tail[mon_q + 1] - q_head[mon_q + 1], 0);
                end
                cur_id = q_ids[mon_q][q_head[mon_q]];
                q_head[mon_q]++;
                cur_port = rd_port;
                cur_word = 0;
                in_pkt = 1'b1;
            end else begin
                check_value("rd_sop", rd_sop, 0);
                check_value("rd_eop", rd_eop, 0);
            end
            if (in_pkt) begin
                check_value("rd_data", rd_data, pkt_words[cur_id][cur_word]);
                check_value("rd_eop", rd_eop, cur_word == pkt_len[cur_id] - 1);
                cur_word++;
                if (cur_word == pkt_len[cur_id]) begin
                    in_pkt = 1'b0;
                    pkts_done++;
                end
            end
        end
    end

    initial begin : stimulus
        logic [DATA_W-1:0] hdr;
        logic              full_seen;
        int                n;
        void'($urandom(47));
        rst_n      = 1'b0;
        in_vld     = 1'b0;
        in_sop     = 1'b0;
        in_eop     = 1'b0;
        in_data    = '0;
        rd_ready   = '0;
        pkts_sent  = 0;
        pkts_done  = 0;
        in_pkt     = 1'b0;
        cur_id     = 0;
        cur_word   = 0;
        cur_port   = '0;
        prio_check = 1'b0;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            q_head[q] = 0;
            q_tail[q] = 0;
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            ready_age[p] = 0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_value("rd_vld", rd_vld, 0);
        check_value("in_full", in_full, 0);

        // both priorities queued on port 2, then the port opens
        for (int i = 0; i < 6; i++) begin
            hdr = DATA_W'($urandom);
            hdr[HDR_PORT_LSB +: PORT_W] = 2'd2;
            hdr[HDR_PRIO_BIT] = (i == 1) || (i > 1 && $urandom_range(0, 1) == 1);
            send_packet($urandom_range(1, 8), hdr);
        end
        repeat (3) @(posedge clk);
        prio_check <= 1'b1;
        rd_ready   <= 4'b0100;
        wait_drained();
        @(posedge clk);
        prio_check <= 1'b0;

        // mixed traffic with ready toggling per packet
        for (int i = 0; i < 150; i++) begin
            @(posedge clk);
            rd_ready <= in_full ? {NUM_PORTS{1'b1}} : NUM_PORTS'($urandom);
            send_packet($urandom_range(1, MAX_PKT_WORDS), DATA_W'($urandom));
        end
        @(posedge clk);
        rd_ready <= {NUM_PORTS{1'b1}};
        wait_drained();

        // fill the buffer with every port held off
        @(posedge clk);
        rd_ready <= '0;
        full_seen = 1'b0;
        n = 0;
        while (!full_seen) begin
            n++;
            if (n > 40) fail_run("in_full never rose while the buffer was filling");
            send_packet($urandom_range(1, MAX_PKT_WORDS), DATA_W'($urandom));
            @(posedge clk);
            full_seen = in_full;
        end
        rd_ready <= {NUM_PORTS{1'b1}};
        n = 0;
        while (in_full) begin
            n++;
            if (n > 5000) fail_run("timeout: in_full did not fall after the ports opened");
            @(posedge clk);
        end
        wait_drained();
        @(posedge clk);
        check_value("in_full", in_full, 0);
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- rtl/switch_buffer_top.sv
`timescale 1ns/1ps

module switch_buffer_top
    import switch_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_vld,
    input  logic                 in_sop,
    input  logic                 in_eop,
    input  logic [DATA_W-1:0]    in_data,
    output logic                 in_full,
    input  logic [NUM_PORTS-1:0] rd_ready,
    output logic                 rd_vld,
    output logic                 rd_sop,
    output logic                 rd_eop,
    output logic [PORT_W-1:0]    rd_port,
    output logic [DATA_W-1:0]    rd_data
);

    logic                              alloc_req;
    logic [PAGE_W-1:0]                 alloc_page;
    logic                              free_req;
    logic [PAGE_W-1:0]                 free_page;
    logic [PAGE_W:0]                   free_count;
    logic                              wr_en;
    logic [PAGE_W-1:0]                 wr_page;
    logic [WORD_IDX_W-1:0]             wr_idx;
    logic [DATA_W-1:0]                 wr_data;
    logic                              link_wr;
    logic [PAGE_W-1:0]                 link_page;
    logic [PAGE_W-1:0]                 link_next;
    logic                              len_wr;
    logic [PAGE_W-1:0]                 len_page;
    logic [LEN_W-1:0]                  len_value;
    logic                              enq;
    logic [QUEUE_W-1:0]                enq_queue;
    logic [PAGE_W-1:0]                 enq_head;
    logic                              deq;
    logic [QUEUE_W-1:0]                deq_queue;
    logic [NUM_QUEUES-1:0]             queue_nonempty;
    logic [NUM_QUEUES-1:0][PAGE_W-1:0] head_pages;
    logic [PAGE_W-1:0]                 rd_page;
    logic [WORD_IDX_W-1:0]             rd_idx;
    logic [DATA_W-1:0]                 buf_rd_data;
    logic [PAGE_W-1:0]                 link_rd_next;
    logic [LEN_W-1:0]                  len_rd;

    // room for one longest packet
    assign in_full = (free_count < MAX_PKT_PAGES);

    write_ctrl u_write_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_vld     (in_vld),
        .in_sop     (in_sop),
        .in_eop     (in_eop),
        .in_data    (in_data),
        .in_full    (in_full),
        .alloc_req  (alloc_req),
        .alloc_page (alloc_page),
        .wr_en      (wr_en),
        .wr_page    (wr_page),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .link_wr    (link_wr),
        .link_page  (link_page),
        .link_next  (link_next),
        .len_wr     (len_wr),
        .len_page   (len_page),
        .len_value  (len_value),
        .enq        (enq),
        .enq_queue  (enq_queue),
        .enq_head   (enq_head)
    );

    read_sched u_read_sched (
        .clk            (clk),
        .rst_n          (rst_n),
        .rd_ready       (rd_ready),
        .queue_nonempty (queue_nonempty),
        .head_pages     (head_pages),
        .deq            (deq),
        .deq_queue      (deq_queue),
        .rd_page        (rd_page),
        .rd_idx         (rd_idx),
        .rd_data        (buf_rd_data),
        .link_rd_next   (link_rd_next),
        .len_rd         (len_rd),
        .free_req       (free_req),
        .free_page      (free_page),
        .out_vld        (rd_vld),
        .out_sop        (rd_sop),
        .out_eop        (rd_eop),
        .out_port       (rd_port),
        .out_data       (rd_data)
    );

    free_page_list u_free_page_list (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc_req  (alloc_req),
        .alloc_page (alloc_page),
        .free_req   (free_req),
        .free_page  (free_page),
        .free_count (free_count)
    );

    page_buffer u_page_buffer (
        .clk          (clk),
        .wr_en        (wr_en),
        .wr_page      (wr_page),
        .wr_idx       (wr_idx),
        .wr_data      (wr_data),
        .link_wr      (link_wr),
        .link_page    (link_page),
        .link_next    (link_next),
        .len_wr       (len_wr),
        .len_page     (len_page),
        .len_value    (len_value),
        .rd_page      (rd_page),
        .rd_idx       (rd_idx),
        .rd_data      (buf_rd_data),
        .link_rd_next (link_rd_next),
        .len_rd       (len_rd)
    );

    queue_table u_queue_table (
        .clk            (clk),
        .rst_n          (rst_n),
        .enq            (enq),
        .enq_queue      (enq_queue),
        .enq_head       (enq_head),
        .deq            (deq),
        .deq_queue      (deq_queue),
        .queue_nonempty (queue_nonempty),
        .head_pages     (head_pages)
    );

endmodule

//--- rtl/read_sched.sv
`timescale 1ns/1ps

module read_sched
    import switch_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [NUM_PORTS-1:0]              rd_ready,
    input  logic [NUM_QUEUES-1:0]             queue_nonempty,
    input  logic [NUM_QUEUES-1:0][PAGE_W-1:0] head_pages,
    output logic                              deq,
    output logic [QUEUE_W-1:0]                deq_queue,
    output logic [PAGE_W-1:0]                 rd_page,
    output logic [WORD_IDX_W-1:0]             rd_idx,
    input  logic [DATA_W-1:0]                 rd_data,
    input  logic [PAGE_W-1:0]                 link_rd_next,
    input  logic [LEN_W-1:0]                  len_rd,
    output logic                              free_req,
    output logic [PAGE_W-1:0]                 free_page,
    output logic                              out_vld,
    output logic                              out_sop,
    output logic                              out_eop,
    output logic [PORT_W-1:0]                 out_port,
    output logic [DATA_W-1:0]                 out_data
);

    rd_state_t          state;
    logic               pick_vld;
    logic [QUEUE_W-1:0] pick_q;
    logic               issue;
    logic               last_word;
    logic [PAGE_W-1:0]  cur_page;
    logic [PORT_W-1:0]  cur_port;
    logic [LEN_W-1:0]   pkt_len;
    logic [LEN_W-1:0]   word_count;
    logic               page_last;

    // later hits override, so prio 1 and the lowest port win
    always_comb begin
        pick_vld = 1'b0;
        pick_q   = '0;
        for (int pr = 0; pr < NUM_PRIOS; pr++) begin
            for (int p = NUM_PORTS - 1; p >= 0; p--) begin
                if (queue_nonempty[p * NUM_PRIOS + pr] && rd_ready[p]) begin
                    pick_vld = 1'b1;
                    pick_q   = QUEUE_W'(p * NUM_PRIOS + pr);
                end
            end
        end
    end

    assign deq       = (state == R_IDLE) && pick_vld;
    assign deq_queue = pick_q;

    assign issue     = (state == R_STREAM);
    assign last_word = (word_count == pkt_len - 1'b1);
    assign rd_page   = cur_page;

    // page goes back once its last word has been addressed
    assign free_req  = issue && (page_last || last_word);
    assign free_page = cur_page;

    page_word_counter rd_count (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (state == R_IDLE),
        .step       (issue),
        .word_idx   (rd_idx),
        .word_count (word_count),
        .page_last  (page_last)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= R_IDLE;
            out_vld <= 1'b0;
            out_sop <= 1'b0;
            out_eop <= 1'b0;
        end else begin
            out_vld <= issue;
            out_sop <= issue && (word_count == '0);
            out_eop <= issue && last_word;
            case (state)
                R_IDLE:   if (pick_vld) state <= R_FETCH;
                R_FETCH:  state <= R_STREAM;
                R_STREAM: if (last_word) state <= R_IDLE;
                default:  state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (deq) begin
            cur_page <= head_pages[pick_q];
            cur_port <= pick_q[QUEUE_W-1 -: PORT_W];
        end else if (issue && page_last && !last_word) begin
            cur_page <= link_rd_next;
        end
        if (state == R_FETCH) begin
            pkt_len <= len_rd;
        end
        out_port <= cur_port;
    end

    // memory read data lines up with the delayed strobes
    assign out_data = rd_data;

    // head page carries a written packet length
    a_fetch_len: assert property (@(posedge clk) disable iff (!rst_n)
        state == R_FETCH |-> (len_rd != '0) && (len_rd <= LEN_W'(MAX_PKT_WORDS)));

endmodule

//--- rtl/write_ctrl.sv
`timescale 1ns/1ps

module write_ctrl
    import switch_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_vld,
    input  logic                  in_sop,
    input  logic                  in_eop,
    input  logic [DATA_W-1:0]     in_data,
    input  logic                  in_full,
    output logic                  alloc_req,
    input  logic [PAGE_W-1:0]     alloc_page,
    output logic                  wr_en,
    output logic [PAGE_W-1:0]     wr_page,
    output logic [WORD_IDX_W-1:0] wr_idx,
    output logic [DATA_W-1:0]     wr_data,
    output logic                  link_wr,
    output logic [PAGE_W-1:0]     link_page,
    output logic [PAGE_W-1:0]     link_next,
    output logic                  len_wr,
    output logic [PAGE_W-1:0]     len_page,
    output logic [LEN_W-1:0]      len_value,
    output logic                  enq,
    output logic [QUEUE_W-1:0]    enq_queue,
    output logic [PAGE_W-1:0]     enq_head
);

    wr_state_t         state;
    logic              start;
    logic              accept;
    logic              need_page;
    logic              enq_pend;
    logic [PAGE_W-1:0] cur_page;
    logic [PAGE_W-1:0] head_page;
    logic [QUEUE_W-1:0] pkt_queue;
    logic [LEN_W-1:0]  pkt_len;
    logic [LEN_W-1:0]  word_count;
    logic              page_last;

    assign start  = (state == W_IDLE) && in_vld && in_sop;
    assign accept = start || ((state == W_DATA) && in_vld);

    // header word and the first word of every later page
    assign alloc_req = start || ((state == W_DATA) && in_vld && need_page);

    assign wr_en   = accept;
    assign wr_page = alloc_req ? alloc_page : cur_page;
    assign wr_data = in_data;

    assign link_wr   = (state == W_DATA) && alloc_req;
    assign link_page = cur_page;
    assign link_next = alloc_page;

    assign len_wr    = enq_pend;
    assign len_page  = head_page;
    assign len_value = pkt_len;
    assign enq       = enq_pend;
    assign enq_queue = pkt_queue;
    assign enq_head  = head_page;

    page_word_counter wr_count (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (accept && in_eop),
        .step       (accept),
        .word_idx   (wr_idx),
        .word_count (word_count),
        .page_last  (page_last)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= W_IDLE;
            need_page <= 1'b0;
            enq_pend  <= 1'b0;
        end else begin
            enq_pend <= accept && in_eop;
            if (alloc_req) begin
                need_page <= 1'b0;
            end else if (accept && page_last && !in_eop) begin
                need_page <= 1'b1;
            end
            if (start && !in_eop) begin
                state <= W_DATA;
            end else if (accept && in_eop) begin
                state <= W_IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_req) begin
            cur_page <= alloc_page;
        end
        if (start) begin
            head_page <= alloc_page;
            pkt_queue <= {in_data[HDR_PORT_LSB +: PORT_W], in_data[HDR_PRIO_BIT]};
        end
        if (accept && in_eop) begin
            pkt_len <= word_count + 1'b1;
        end
    end

    // in_full is a packet-level gate from the top
    a_no_sop_full: assert property (@(posedge clk) disable iff (!rst_n)
        in_vld && in_sop |-> !in_full);

endmodule

//--- rtl/queue_table.sv
`timescale 1ns/1ps

module queue_table
    import switch_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               enq,
    input  logic [QUEUE_W-1:0]                 enq_queue,
    input  logic [PAGE_W-1:0]                  enq_head,
    input  logic                               deq,
    input  logic [QUEUE_W-1:0]                 deq_queue,
    output logic [NUM_QUEUES-1:0]              queue_nonempty,
    output logic [NUM_QUEUES-1:0][PAGE_W-1:0]  head_pages
);

    logic [PAGE_W-1:0] head  [NUM_QUEUES];
    logic [PAGE_W-1:0] tail  [NUM_QUEUES];
    logic [PAGE_W:0]   count [NUM_QUEUES];
    // next packet's head page, indexed by head page
    logic [PAGE_W-1:0] chain [NUM_PAGES];
    logic              enq_to_empty;

    // a dequeue of the last packet in the same cycle leaves the queue empty
    assign enq_to_empty = (count[enq_queue] == '0) ||
                          (deq && deq_queue == enq_queue && count[enq_queue] == 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                count[q] <= '0;
            end
        end else begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                count[q] <= count[q]
                          + (PAGE_W + 1)'(enq && enq_queue == QUEUE_W'(q))
                          - (PAGE_W + 1)'(deq && deq_queue == QUEUE_W'(q));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (deq) begin
            head[deq_queue] <= chain[head[deq_queue]];
        end
        if (enq) begin
            if (enq_to_empty) begin
                head[enq_queue] <= enq_head;
            end else begin
                chain[tail[enq_queue]] <= enq_head;
            end
            tail[enq_queue] <= enq_head;
        end
    end

    always_comb begin
        for (int q = 0; q < NUM_QUEUES; q++) begin
            queue_nonempty[q] = (count[q] != '0);
            head_pages[q]     = head[q];
        end
    end

    a_no_deq_empty: assert property (@(posedge clk) disable iff (!rst_n)
        deq |-> queue_nonempty[deq_queue]);

endmodule

//--- rtl/page_buffer.sv
`timescale 1ns/1ps

module page_buffer
    import switch_pkg::*;
(
    input  logic                  clk,
    input  logic                  wr_en,
    input  logic [PAGE_W-1:0]     wr_page,
    input  logic [WORD_IDX_W-1:0] wr_idx,
    input  logic [DATA_W-1:0]     wr_data,
    input  logic                  link_wr,
    input  logic [PAGE_W-1:0]     link_page,
    input  logic [PAGE_W-1:0]     link_next,
    input  logic                  len_wr,
    input  logic [PAGE_W-1:0]     len_page,
    input  logic [LEN_W-1:0]      len_value,
    input  logic [PAGE_W-1:0]     rd_page,
    input  logic [WORD_IDX_W-1:0] rd_idx,
    output logic [DATA_W-1:0]     rd_data,
    output logic [PAGE_W-1:0]     link_rd_next,
    output logic [LEN_W-1:0]      len_rd
);

    logic [DATA_W-1:0] words [NUM_PAGES * PAGE_WORDS];
    logic [PAGE_W-1:0] links [NUM_PAGES];
    // only meaningful on head pages
    logic [LEN_W-1:0]  lens  [NUM_PAGES];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            words[{wr_page, wr_idx}] <= wr_data;
        end
        if (link_wr) begin
            links[link_page] <= link_next;
        end
        if (len_wr) begin
            lens[len_page] <= len_value;
        end
        rd_data <= words[{rd_page, rd_idx}];
    end

    assign link_rd_next = links[rd_page];
    assign len_rd       = lens[rd_page];

endmodule

//--- rtl/free_page_list.sv
`timescale 1ns/1ps

module free_page_list
    import switch_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              alloc_req,
    output logic [PAGE_W-1:0] alloc_page,
    input  logic              free_req,
    input  logic [PAGE_W-1:0] free_page,
    output logic [PAGE_W:0]   free_count
);

    logic [PAGE_W-1:0] pool [NUM_PAGES];
    logic [PAGE_W-1:0] rd_ptr;
    logic [PAGE_W-1:0] wr_ptr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PAGES; i++) begin
                pool[i] <= PAGE_W'(i);
            end
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            free_count <= (PAGE_W + 1)'(NUM_PAGES);
        end else begin
            if (alloc_req) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (free_req) begin
                pool[wr_ptr] <= free_page;
                wr_ptr       <= wr_ptr + 1'b1;
            end
            free_count <= free_count + (PAGE_W + 1)'(free_req) - (PAGE_W + 1)'(alloc_req);
        end
    end

    // head of the pool, valid in the same cycle
    assign alloc_page = pool[rd_ptr];

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_req |-> free_count != '0);

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        free_req |-> free_count != (PAGE_W + 1)'(NUM_PAGES));

endmodule

//--- rtl/page_word_counter.sv
`timescale 1ns/1ps

module page_word_counter
    import switch_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clear,
    input  logic                  step,
    output logic [WORD_IDX_W-1:0] word_idx,
    output logic [LEN_W-1:0]      word_count,
    output logic                  page_last
);

    // clear wins over step
    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            word_idx   <= '0;
            word_count <= '0;
        end else if (step) begin
            word_idx   <= word_idx + 1'b1;
            word_count <= word_count + 1'b1;
        end
    end

    // word_idx wraps on its own at a page boundary
    assign page_last = (word_idx == WORD_IDX_W'(PAGE_WORDS - 1));

endmodule

//--- rtl/switch_pkg.sv
package switch_pkg;

    localparam int DATA_W = 16;

    localparam int NUM_PORTS = 4;
    localparam int PORT_W = 2;
    localparam int NUM_PRIOS = 2;
    // queue index is {port, prio}
    localparam int NUM_QUEUES = NUM_PORTS * NUM_PRIOS;
    localparam int QUEUE_W = 3;

    localparam int PAGE_WORDS = 8;
    localparam int WORD_IDX_W = 3;
    localparam int NUM_PAGES = 32;
    localparam int PAGE_W = 5;

    // header word included
    localparam int MAX_PKT_WORDS = 32;
    localparam int LEN_W = $clog2(MAX_PKT_WORDS + 1);
    localparam int MAX_PKT_PAGES = 4;

    // header layout, first word of a packet
    localparam int HDR_PORT_LSB = 0;
    localparam int HDR_PRIO_BIT = 2;

    typedef enum logic {W_IDLE, W_DATA} wr_state_t;

    typedef enum logic [1:0] {R_IDLE, R_FETCH, R_STREAM} rd_state_t;

endpackage
